//--- Makefile
# Verilator flow for the 4x4 packet crossbar

VERILATOR ?= verilator
TOP       ?= tb_xbar
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert
JOBS      ?= 0
PASS_MSG  ?= TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary -j $(JOBS) $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_xbar.sv
`timescale 1ns/1ps

`include "xbar_cfg.svh"

module tb_xbar;

    localparam int P = `XBAR_PORTS;

    logic                           i_clk;
    logic                           i_rst;
    logic [P-1:0]                   i_s_valid;
    logic [P-1:0][`XBAR_DATA_W-1:0] i_s_data;
    logic [P-1:0][`XBAR_KEEP_W-1:0] i_s_keep;
    logic [P-1:0]                   i_s_last;
    logic [P-1:0][`XBAR_DEST_W-1:0] i_s_dest;
    logic [P-1:0]                   o_m_valid;
    logic [P-1:0][`XBAR_DATA_W-1:0] o_m_data;
    logic [P-1:0][`XBAR_KEEP_W-1:0] o_m_keep;
    logic [P-1:0]                   o_m_last;
    logic [P-1:0]                   i_m_ready;

    // Beats waiting to be driven, and expected beats per output and source
    xbar_pkg::beat_t         tx_q    [P][$];
    logic [`XBAR_DEST_W-1:0] dest_q  [P][$];
    xbar_pkg::beat_t         exp_q   [P][P][$];
    int                      order_q [P][$];
    int                      pkt_cnt [P];
    int                      cur_src [P];
    xbar_pkg::beat_t         held    [P];
    logic [P-1:0]            in_pkt;
    logic [P-1:0]            stalled;
    logic                    rand_ready;
    int                      err_value;
    int                      err_other;

    xbar_top u_dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    function automatic void compare_value(string name, logic [63:0] exp, logic [63:0] got);
        assert (exp == got) else begin
            err_value++;
            $display("FAILED %s exp %h got %h", name, exp, got);
        end
    endfunction

    function automatic void require(bit cond, string what);
        assert (cond) else begin
            err_other++;
            $display("%s", what);
        end
    endfunction

    // Data is input, packet number, beat index, then random filler
    function automatic void queue_packet(int src, int dst, int len);
        xbar_pkg::beat_t b;
        for (int i = 0; i < len; i++) begin
            b.data = {8'(src), 8'(pkt_cnt[src]), 16'(i), 32'($urandom)};
            b.keep = (i == len - 1) ? 8'($urandom_range(255, 1)) : 8'hff;
            b.last = (i == len - 1);
            tx_q[src].push_back(b);
            // Later beats carry junk destinations
            dest_q[src].push_back((i == 0) ? `XBAR_DEST_W'(dst) : `XBAR_DEST_W'($urandom));
            exp_q[dst][src].push_back(b);
        end
        pkt_cnt[src]++;
    endfunction

    function automatic bit all_drained();
        for (int n = 0; n < P; n++) begin
            if (tx_q[n].size() != 0) return 1'b0;
            for (int m = 0; m < P; m++) begin
                if (exp_q[m][n].size() != 0) return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic wait_drained(int max_cycles, string what);
        int c;
        c = 0;
        while (!all_drained() && c < max_cycles) begin
            @(posedge i_clk);
            c++;
        end
        require(all_drained(), $sformatf("timeout, %s traffic never drained", what));
        repeat (2) @(posedge i_clk);
    endtask

    task automatic apply_reset();
        @(negedge i_clk);
        i_rst = 1'b1;
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Source driver and output monitor
    //////////////////////////////////////////////////

    initial begin
        i_s_valid = '0;
        i_s_data  = '0;
        i_s_keep  = '0;
        i_s_last  = '0;
        i_s_dest  = '0;
        forever begin
            @(negedge i_clk);
            for (int n = 0; n < P; n++) begin
                i_s_valid[n] = (tx_q[n].size() > 0);
                if (i_s_valid[n]) begin
                    i_s_data[n] = tx_q[n][0].data;
                    i_s_keep[n] = tx_q[n][0].keep;
                    i_s_last[n] = tx_q[n][0].last;
                    i_s_dest[n] = dest_q[n].pop_front();
                    tx_q[n].delete(0);
                end
            end
        end
    end

    function automatic void check_beat(int m, xbar_pkg::beat_t got);
        int              src;
        bit              known;
        xbar_pkg::beat_t exp;
        src = int'(got.data[`XBAR_DATA_W-1 -: 8]);
        if (in_pkt[m]) begin
            compare_value($sformatf("o_m_data[%0d] source", m), 64'(cur_src[m]), 64'(src));
        end else begin
            order_q[m].push_back(src);
        end
        cur_src[m] = src;
        in_pkt[m]  = !got.last;
        known = (src < P) && (exp_q[m][src].size() > 0);
        require(known, $sformatf("output %0d delivered a beat nobody sent to it", m));
        if (known) begin
            exp = exp_q[m][src].pop_front();
            compare_value($sformatf("o_m_data[%0d]", m), exp.data, got.data);
            compare_value($sformatf("o_m_keep[%0d]", m), 64'(exp.keep), 64'(got.keep));
            compare_value($sformatf("o_m_last[%0d]", m), 64'(exp.last), 64'(got.last));
        end
    endfunction

    // Outputs settle after the rising edge, so the falling edge is safe
    initial begin
        xbar_pkg::beat_t got;
        i_m_ready = '1;
        in_pkt    = '0;
        stalled   = '0;
        forever begin
            @(negedge i_clk);
            for (int m = 0; m < P; m++) begin
                i_m_ready[m] = rand_ready ? 1'($urandom) : 1'b1;
                got = '{data: o_m_data[m], keep: o_m_keep[m], last: o_m_last[m]};
                if (stalled[m]) begin
                    require(o_m_valid[m], $sformatf("output %0d dropped valid in a stall", m));
                    compare_value($sformatf("o_m_data[%0d] stalled", m), held[m].data, got.data);
                    compare_value($sformatf("o_m_keep[%0d] stalled", m),
                                  64'(held[m].keep), 64'(got.keep));
                    compare_value($sformatf("o_m_last[%0d] stalled", m),
                                  64'(held[m].last), 64'(got.last));
                end
                stalled[m] = o_m_valid[m] && !i_m_ready[m];
                held[m]    = got;
                if (o_m_valid[m] && i_m_ready[m]) begin
                    check_beat(m, got);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_routing();
        @(posedge i_clk);
        for (int p = 0; p < P; p++) begin
            for (int n = 0; n < P; n++) begin
                queue_packet(n, (n + p) % P, $urandom_range(3, 1));
            end
        end
        wait_drained(400, "routing");
    endtask

    task automatic test_no_interleave();
        @(posedge i_clk);
        order_q[1].delete();
        queue_packet(0, 1, 6);
        queue_packet(2, 1, 6);
        wait_drained(100, "interleave");
        require(order_q[1].size() == 2, "output 1 did not complete both packets");
    endtask

    task automatic test_round_robin();
        apply_reset();
        @(posedge i_clk);
        order_q[0].delete();
        for (int n = 0; n < P; n++) begin
            queue_packet(n, 0, 2);
        end
        wait_drained(100, "first arbitration round");
        require(order_q[0].size() == 4, "output 0 missed packets in the first round");
        for (int i = 0; i < order_q[0].size(); i++) begin
            compare_value("o_m_data[0] winner", 64'(i), 64'(order_q[0][i]));
        end
        order_q[0].delete();
        queue_packet(1, 0, 2);
        queue_packet(3, 0, 2);
        wait_drained(100, "second arbitration round");
        require(order_q[0].size() == 2, "output 0 missed packets in the second round");
        for (int i = 0; i < order_q[0].size(); i++) begin
            compare_value("o_m_data[0] winner", 64'(1 + 2 * i), 64'(order_q[0][i]));
        end
    endtask

    task automatic test_backpressure();
        @(posedge i_clk);
        rand_ready = 1'b1;
        for (int k = 0; k < 2; k++) begin
            for (int n = 0; n < P; n++) begin
                queue_packet(n, (n % 2 == 1) ? 3 : 2, 4);
            end
        end
        wait_drained(600, "back-pressure");
        rand_ready = 1'b0;
    endtask

    task automatic test_parallel();
        @(posedge i_clk);
        for (int m = 0; m < P; m++) begin
            order_q[m].delete();
        end
        for (int n = 0; n < P; n++) begin
            queue_packet(n, P - 1 - n, 5);
            queue_packet(n, P - 1 - n, 5);
        end
        wait_drained(200, "parallel");
        for (int m = 0; m < P; m++) begin
            require(order_q[m].size() == 2, $sformatf("output %0d missed packets", m));
            for (int i = 0; i < order_q[m].size(); i++) begin
                compare_value($sformatf("o_m_data[%0d] source", m), 64'(P - 1 - m),
                              64'(order_q[m][i]));
            end
        end
    endtask

    initial begin
        void'($urandom(32'h8086d0c9));
        i_rst      = 1'b1;
        rand_ready = 1'b0;
        err_value  = 0;
        err_other  = 0;
        for (int n = 0; n < P; n++) begin
            pkt_cnt[n] = 0;
        end
        apply_reset();
        test_routing();
        test_no_interleave();
        test_round_robin();
        test_backpressure();
        test_parallel();
        $display("errors: wrong values %0d, other failures %0d", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- common/xbar_cfg.svh
`ifndef XBAR_CFG_SVH
`define XBAR_CFG_SVH

// Crossbar dimensions

// Inputs and outputs
`define XBAR_PORTS      4

// Beat payload
`define XBAR_DATA_W     64
`define XBAR_KEEP_W     8

// Binary select of one of four outputs
`define XBAR_DEST_W     2

// Beats buffered per input
`define XBAR_FIFO_DEPTH 16

`endif

//--- common/xbar_pkg.sv
`include "xbar_cfg.svh"

package xbar_pkg;

    //////////////////////////////////////////////////
    // Stream beat
    //////////////////////////////////////////////////

    // 64 data + 8 keep + 1 last = 73 bits
    typedef struct packed {
        logic [`XBAR_DATA_W-1:0] data;
        logic [`XBAR_KEEP_W-1:0] keep;
        logic                    last;
    } beat_t;

    //////////////////////////////////////////////////
    // Port vectors
    //////////////////////////////////////////////////

    // Requests, grants and pops, bit n is port n
    typedef logic [`XBAR_PORTS-1:0] port_vec_t;

endpackage

//--- hw/egress/xbar_egress.sv
`timescale 1ns/1ps

`include "xbar_cfg.svh"

module xbar_egress (
    input  logic                i_clk,
    input  logic                i_rst,
    input  xbar_pkg::port_vec_t i_req,
    input  xbar_pkg::beat_t     i_heads [`XBAR_PORTS],
    input  xbar_pkg::port_vec_t i_head_valid,
    input  logic                i_ready,
    output logic                o_valid,
    output xbar_pkg::beat_t     o_beat,
    output xbar_pkg::port_vec_t o_pop
);

    logic                r_locked;
    xbar_pkg::port_vec_t r_grant;
    xbar_pkg::port_vec_t w_arb_grant;
    logic                w_lock_now;
    logic                w_xfer;

    //////////////////////////////////////////////////
    // Arbitration and packet lock
    //////////////////////////////////////////////////

    assign w_lock_now = !r_locked && (|i_req);

    xbar_rr_arbiter u_arb (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_req     (i_req),
        .i_advance (w_lock_now),
        .o_grant   (w_arb_grant)
    );

    // Held until the last beat of the packet leaves
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_locked <= 1'b0;
            r_grant  <= '0;
        end else if (w_lock_now) begin
            r_locked <= 1'b1;
            r_grant  <= w_arb_grant;
        end else if (w_xfer && o_beat.last) begin
            r_locked <= 1'b0;
            r_grant  <= '0;
        end
    end

    //////////////////////////////////////////////////
    // Beat select and pop
    //////////////////////////////////////////////////

    always_comb begin
        o_beat = '0;
        for (int n = 0; n < `XBAR_PORTS; n++) begin
            if (r_grant[n]) begin
                o_beat = i_heads[n];
            end
        end
    end

    // Valid tracks whether the locked input has a beat at its head
    assign o_valid = r_locked && (|(r_grant & i_head_valid));
    assign w_xfer  = o_valid && i_ready;
    assign o_pop   = w_xfer ? r_grant : '0;

    // Stalled beat must hold until accepted
    a_stall_stable: assert property (
        @(posedge i_clk) disable iff (i_rst)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_beat))
    );

endmodule

//--- hw/egress/xbar_rr_arbiter.sv
`timescale 1ns/1ps

`include "xbar_cfg.svh"

module xbar_rr_arbiter (
    input  logic                i_clk,
    input  logic                i_rst,
    input  xbar_pkg::port_vec_t i_req,
    input  logic                i_advance,
    output xbar_pkg::port_vec_t o_grant
);

    localparam int PW = $clog2(`XBAR_PORTS);

    logic [PW-1:0] r_ptr;
    logic [PW-1:0] w_win;

    // Search from the pointer upward and wrap
    always_comb begin
        logic [PW-1:0] v_idx;
        logic          v_found;
        o_grant = '0;
        w_win   = r_ptr;
        v_found = 1'b0;
        for (int i = 0; i < `XBAR_PORTS; i++) begin
            v_idx = PW'((int'(r_ptr) + i) % `XBAR_PORTS);
            if (!v_found && i_req[v_idx]) begin
                v_found        = 1'b1;
                o_grant[v_idx] = 1'b1;
                w_win          = v_idx;
            end
        end
    end

    // Winner drops to lowest priority
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_ptr <= '0;
        end else if (i_advance) begin
            r_ptr <= PW'((int'(w_win) + 1) % `XBAR_PORTS);
        end
    end

    a_grant_onehot: assert property (
        @(posedge i_clk) disable iff (i_rst)
        $onehot0(o_grant)
    );

endmodule

//--- hw/ingress/xbar_ingress.sv
`timescale 1ns/1ps

`include "xbar_cfg.svh"

module xbar_ingress (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_valid,
    input  xbar_pkg::beat_t         i_beat,
    input  logic [`XBAR_DEST_W-1:0] i_dest,
    input  logic                    i_pop,
    output xbar_pkg::beat_t         o_head,
    output xbar_pkg::port_vec_t     o_req,
    output logic                    o_head_valid
);

    localparam int AW = $clog2(`XBAR_FIFO_DEPTH);

    xbar_pkg::beat_t         r_mem      [`XBAR_FIFO_DEPTH];
    logic [`XBAR_DEST_W-1:0] r_dest_mem [`XBAR_FIFO_DEPTH];

    // Extra top bit tells full from empty
    logic [AW:0] r_wr_ptr;
    logic [AW:0] r_rd_ptr;

    logic                    r_in_pkt;
    logic [`XBAR_DEST_W-1:0] r_pkt_dest;
    logic [`XBAR_DEST_W-1:0] w_wr_dest;
    logic [`XBAR_DEST_W-1:0] w_head_dest;
    logic                    w_empty;
    logic                    w_full;

    assign w_empty = (r_wr_ptr == r_rd_ptr);
    assign w_full  = (r_wr_ptr[AW-1:0] == r_rd_ptr[AW-1:0]) &&
                     (r_wr_ptr[AW] != r_rd_ptr[AW]);

    //////////////////////////////////////////////////
    // Packet destination tracking
    //////////////////////////////////////////////////

    // Only the first beat carries a valid destination
    assign w_wr_dest = r_in_pkt ? r_pkt_dest : i_dest;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_in_pkt   <= 1'b0;
            r_pkt_dest <= '0;
        end else if (i_valid) begin
            r_in_pkt <= !i_beat.last;
            if (!r_in_pkt) begin
                r_pkt_dest <= i_dest;
            end
        end
    end

    //////////////////////////////////////////////////
    // Beat FIFO
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            r_mem[r_wr_ptr[AW-1:0]]      <= i_beat;
            r_dest_mem[r_wr_ptr[AW-1:0]] <= w_wr_dest;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
        end else begin
            if (i_valid) begin
                r_wr_ptr <= r_wr_ptr + 1'b1;
            end
            if (i_pop) begin
                r_rd_ptr <= r_rd_ptr + 1'b1;
            end
        end
    end

    // Head is presented straight from storage
    assign w_head_dest  = r_dest_mem[r_rd_ptr[AW-1:0]];
    assign o_head       = r_mem[r_rd_ptr[AW-1:0]];
    assign o_head_valid = !w_empty;

    // One-hot request toward the head beat's output
    assign o_req = w_empty ? '0 : (xbar_pkg::port_vec_t'(1) << w_head_dest);

    // Source has no back-pressure, so it must never overrun the FIFO
    a_no_overflow: assert property (
        @(posedge i_clk) disable iff (i_rst)
        !(i_valid && w_full)
    );

    // Egress pops only a head it has seen as present
    a_no_underflow: assert property (
        @(posedge i_clk) disable iff (i_rst)
        !(i_pop && w_empty)
    );

endmodule

//--- hw/xbar_top.sv
`timescale 1ns/1ps

`include "xbar_cfg.svh"

module xbar_top (
    input  logic                                     i_clk,
    input  logic                                     i_rst,
    input  logic [`XBAR_PORTS-1:0]                   i_s_valid,
    input  logic [`XBAR_PORTS-1:0][`XBAR_DATA_W-1:0] i_s_data,
    input  logic [`XBAR_PORTS-1:0][`XBAR_KEEP_W-1:0] i_s_keep,
    input  logic [`XBAR_PORTS-1:0]                   i_s_last,
    input  logic [`XBAR_PORTS-1:0][`XBAR_DEST_W-1:0] i_s_dest,
    output logic [`XBAR_PORTS-1:0]                   o_m_valid,
    output logic [`XBAR_PORTS-1:0][`XBAR_DATA_W-1:0] o_m_data,
    output logic [`XBAR_PORTS-1:0][`XBAR_KEEP_W-1:0] o_m_keep,
    output logic [`XBAR_PORTS-1:0]                   o_m_last,
    input  logic [`XBAR_PORTS-1:0]                   i_m_ready
);

    xbar_pkg::beat_t     w_in_beat [`XBAR_PORTS];
    xbar_pkg::beat_t     w_heads   [`XBAR_PORTS];
    xbar_pkg::beat_t     w_out_beat[`XBAR_PORTS];
    xbar_pkg::port_vec_t w_head_valid;
    xbar_pkg::port_vec_t w_req     [`XBAR_PORTS];
    xbar_pkg::port_vec_t w_eg_req  [`XBAR_PORTS];
    xbar_pkg::port_vec_t w_eg_pop  [`XBAR_PORTS];
    xbar_pkg::port_vec_t w_in_pop;

    // Requests by input become requests by output, pops OR per input
    always_comb begin
        w_in_pop = '0;
        for (int m = 0; m < `XBAR_PORTS; m++) begin
            for (int n = 0; n < `XBAR_PORTS; n++) begin
                w_eg_req[m][n] = w_req[n][m];
                w_in_pop[n]    = w_in_pop[n] | w_eg_pop[m][n];
            end
        end
    end

    for (genvar n = 0; n < `XBAR_PORTS; n++) begin : g_ingress
        assign w_in_beat[n].data = i_s_data[n];
        assign w_in_beat[n].keep = i_s_keep[n];
        assign w_in_beat[n].last = i_s_last[n];

        xbar_ingress u_ingress (
            .i_clk        (i_clk),
            .i_rst        (i_rst),
            .i_valid      (i_s_valid[n]),
            .i_beat       (w_in_beat[n]),
            .i_dest       (i_s_dest[n]),
            .i_pop        (w_in_pop[n]),
            .o_head       (w_heads[n]),
            .o_req        (w_req[n]),
            .o_head_valid (w_head_valid[n])
        );
    end

    for (genvar m = 0; m < `XBAR_PORTS; m++) begin : g_egress
        xbar_egress u_egress (
            .i_clk        (i_clk),
            .i_rst        (i_rst),
            .i_req        (w_eg_req[m]),
            .i_heads      (w_heads),
            .i_head_valid (w_head_valid),
            .i_ready      (i_m_ready[m]),
            .o_valid      (o_m_valid[m]),
            .o_beat       (w_out_beat[m]),
            .o_pop        (w_eg_pop[m])
        );

        assign o_m_data[m] = w_out_beat[m].data;
        assign o_m_keep[m] = w_out_beat[m].keep;
        assign o_m_last[m] = w_out_beat[m].last;
    end

endmodule

//--- list.f
+incdir+common
common/xbar_pkg.sv
hw/ingress/xbar_ingress.sv
hw/egress/xbar_rr_arbiter.sv
hw/egress/xbar_egress.sv
hw/xbar_top.sv
bench/tb_xbar.sv
